//--- Bender.yml
package:
  name: host_domain

sources:
  - common/host_pkg.sv
  - l2/l2_bank.sv
  - l2/l2_memory.sv
  - logic/evt_receiver.sv
  - logic/cfg_regs.sv
  - logic/host_router.sv
  - logic/host_domain.sv
  - target: test
    files:
      - tb/host_domain_assertions.sv
      - tb/tb_host_domain.sv

//--- common/host_pkg.sv
// ==========================================================
// Host hub package
// Address layout, request and response words, region codes
// and the register map of the configuration block
// ==========================================================

package host_pkg;

  typedef logic [31:0] addr_t;

  // Top nibble of the address selects the target
  typedef enum logic [3:0] {
    REGION_L2  = 4'd1,
    REGION_CFG = 4'd2
  } region_e;

  typedef struct packed {
    logic [25:0] word;
    logic [1:0]  byte_off;
  } l2_off_t;

  typedef struct packed {
    logic [21:0] unused;
    logic [3:0]  reg_idx;
    logic [1:0]  byte_off;
  } cfg_off_t;

  // Same 28 offset bits seen as L2 location or register
  typedef union packed {
    l2_off_t  l2;
    cfg_off_t cfg;
  } offset_u;

  typedef struct packed {
    region_e region;
    offset_u offset;
  } host_addr_t;

  typedef struct packed {
    host_addr_t  addr;
    logic        we;
    logic [31:0] wdata;
    logic [3:0]  be;
  } host_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } host_rsp_t;

  typedef struct packed {
    logic [25:0] word;
    logic        we;
    logic [31:0] wdata;
    logic [3:0]  be;
  } mem_req_t;

  typedef struct packed {
    logic [3:0]  idx;
    logic        we;
    logic [31:0] wdata;
    logic [3:0]  be;
  } cfg_req_t;

  localparam logic [3:0] CFG_ID         = 4'd0;
  localparam logic [3:0] CFG_SCRATCH    = 4'd1;
  localparam logic [3:0] CFG_IRQ_STATUS = 4'd2;
  localparam logic [3:0] CFG_IRQ_MASK   = 4'd3;
  localparam logic [3:0] CFG_EVT_COUNT  = 4'd4;

  localparam logic [31:0] HOST_ID           = 32'h4844_0001;
  localparam logic [31:0] CFG_DEFAULT_RDATA = 32'hdeadf000;

  localparam int unsigned NB_L2_BANKS_DEFAULT   = 4;
  localparam int unsigned L2_BANK_WORDS_DEFAULT = 256;

endpackage

//--- host_domain.f
common/host_pkg.sv
l2/l2_bank.sv
l2/l2_memory.sv
logic/evt_receiver.sv
logic/cfg_regs.sv
logic/host_router.sv
logic/host_domain.sv
tb/host_domain_assertions.sv
tb/tb_host_domain.sv

//--- l2/l2_bank.sv
// ==========================================================
// L2 bank
// Single-port word array, byte-enabled write, registered read
// ==========================================================

`timescale 1ns/1ps

module l2_bank #(
  parameter int unsigned WORDS = 256
) (
  input  logic                     clk_i,
  input  logic                     en_i,
  input  logic                     we_i,
  input  logic [$clog2(WORDS)-1:0] addr_i,
  input  logic [31:0]              wdata_i,
  input  logic [3:0]               be_i,
  output logic [31:0]              rdata_o
);

  logic [31:0] mem_q [WORDS];

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        for (int i = 0; i < 4; i++) begin
          if (be_i[i]) mem_q[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

//--- l2/l2_memory.sv
// ==========================================================
// L2 scratchpad
// Word-interleaved banks, one access per cycle, data returned
// one cycle after the enable
// ==========================================================

`timescale 1ns/1ps

module l2_memory #(
  parameter int unsigned NB_L2_BANKS   = 4,
  parameter int unsigned L2_BANK_WORDS = 256
) (
  input  logic               clk_i,
  input  host_pkg::mem_req_t mem_req_i,
  input  logic               mem_en_i,
  output logic [31:0]        rdata_o
);

  localparam int unsigned BANK_W = $clog2(NB_L2_BANKS);
  localparam int unsigned ROW_W  = $clog2(L2_BANK_WORDS);

  logic [BANK_W-1:0]                bank_sel;
  logic [BANK_W-1:0]                bank_sel_q;
  logic [ROW_W-1:0]                 row;
  logic [NB_L2_BANKS-1:0][31:0]     bank_rdata;

  // Low word bits pick the bank, the rest the row
  assign bank_sel = BANK_W'(mem_req_i.word % NB_L2_BANKS);
  assign row      = ROW_W'(mem_req_i.word / NB_L2_BANKS);

  for (genvar b = 0; b < NB_L2_BANKS; b++) begin : gen_bank
    l2_bank #(
      .WORDS ( L2_BANK_WORDS )
    ) i_l2_bank (
      .clk_i   ( clk_i                                     ),
      .en_i    ( mem_en_i && (bank_sel == BANK_W'(b))      ),
      .we_i    ( mem_req_i.we                              ),
      .addr_i  ( row                                       ),
      .wdata_i ( mem_req_i.wdata                           ),
      .be_i    ( mem_req_i.be                              ),
      .rdata_o ( bank_rdata[b]                             )
    );
  end

  // Remember which bank answers next cycle
  always_ff @(posedge clk_i) begin
    if (mem_en_i) bank_sel_q <= bank_sel;
  end

  assign rdata_o = bank_rdata[bank_sel_q];

endmodule

//--- logic/cfg_regs.sv
// ==========================================================
// Configuration registers
// ID, scratch, interrupt status and mask, DMA event counter
// Unmapped indices answer a fixed pattern
// ==========================================================

`timescale 1ns/1ps

module cfg_regs (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  host_pkg::cfg_req_t cfg_req_i,
  input  logic               cfg_en_i,
  output logic [31:0]        rdata_o,
  input  logic               dma_evt_i,
  input  logic               cluster_eoc_i,
  output logic               irq_o
);

  logic [31:0] scratch_q;
  logic [1:0]  status_q;
  logic [1:0]  status_d;
  logic [1:0]  mask_q;
  logic [31:0] count_q;
  logic [31:0] rdata_q;
  logic [31:0] rdata_d;
  logic        irq_q;
  logic        wr;

  assign wr = cfg_en_i && cfg_req_i.we;

  // A new event in the same cycle wins over write-1-to-clear
  always_comb begin
    status_d = status_q;
    if (wr && (cfg_req_i.idx == host_pkg::CFG_IRQ_STATUS) && cfg_req_i.be[0]) begin
      status_d = status_q & ~cfg_req_i.wdata[1:0];
    end
    status_d = status_d | {cluster_eoc_i, dma_evt_i};
  end

  always_comb begin
    case (cfg_req_i.idx)
      host_pkg::CFG_ID:         rdata_d = host_pkg::HOST_ID;
      host_pkg::CFG_SCRATCH:    rdata_d = scratch_q;
      host_pkg::CFG_IRQ_STATUS: rdata_d = {30'd0, status_q};
      host_pkg::CFG_IRQ_MASK:   rdata_d = {30'd0, mask_q};
      host_pkg::CFG_EVT_COUNT:  rdata_d = count_q;
      default:                  rdata_d = host_pkg::CFG_DEFAULT_RDATA;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      scratch_q <= '0;
      status_q  <= '0;
      mask_q    <= '0;
      count_q   <= '0;
      irq_q     <= 1'b0;
    end else begin
      status_q <= status_d;
      irq_q    <= |(status_q & mask_q);
      if (dma_evt_i) count_q <= count_q + 32'd1;
      if (wr && (cfg_req_i.idx == host_pkg::CFG_SCRATCH)) begin
        for (int i = 0; i < 4; i++) begin
          if (cfg_req_i.be[i]) scratch_q[8*i +: 8] <= cfg_req_i.wdata[8*i +: 8];
        end
      end
      if (wr && (cfg_req_i.idx == host_pkg::CFG_IRQ_MASK) && cfg_req_i.be[0]) begin
        mask_q <= cfg_req_i.wdata[1:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cfg_en_i && !cfg_req_i.we) rdata_q <= rdata_d;
  end

  assign rdata_o = rdata_q;
  assign irq_o   = irq_q;

endmodule

//--- logic/evt_receiver.sv
// ==========================================================
// DMA event receiver
// Four-phase valid/ack crossing with a one-cycle event pulse
// ==========================================================

`timescale 1ns/1ps

module evt_receiver (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic valid_i,
  output logic ack_o,
  output logic evt_o
);

  logic [1:0] sync_q;
  logic       level_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q  <= 2'b00;
      level_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], valid_i};
      level_q <= sync_q[1];
    end
  end

  // Ack mirrors the synchronized level
  assign ack_o = sync_q[1];

  // One pulse per rising edge of the synchronized level
  assign evt_o = sync_q[1] && !level_q;

endmodule

//--- logic/host_domain.sv
// ==========================================================
// Host domain
// Host request router with L2 scratchpad, configuration
// registers and the cluster DMA event crossing
// ==========================================================

`timescale 1ns/1ps

module host_domain #(
  parameter int unsigned NB_L2_BANKS   = host_pkg::NB_L2_BANKS_DEFAULT,
  parameter int unsigned L2_BANK_WORDS = host_pkg::L2_BANK_WORDS_DEFAULT
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  host_pkg::host_req_t host_req_i,
  input  logic                host_req_valid_i,
  output logic                host_req_ready_o,
  output host_pkg::host_rsp_t host_rsp_o,
  output logic                host_rsp_valid_o,
  input  logic                host_rsp_ready_i,
  input  logic                dma_pe_evt_valid_i,
  output logic                dma_pe_evt_ack_o,
  input  logic                cluster_eoc_i,
  output logic                irq_o
);

  host_pkg::mem_req_t mem_req;
  logic               mem_en;
  logic [31:0]        mem_rdata;
  host_pkg::cfg_req_t cfg_req;
  logic               cfg_en;
  logic [31:0]        cfg_rdata;
  logic               dma_evt;

  host_router #(
    .NB_L2_BANKS   ( NB_L2_BANKS   ),
    .L2_BANK_WORDS ( L2_BANK_WORDS )
  ) i_host_router (
    .clk_i            ( clk_i            ),
    .arst_n_i         ( arst_n_i         ),
    .host_req_i       ( host_req_i       ),
    .host_req_valid_i ( host_req_valid_i ),
    .host_req_ready_o ( host_req_ready_o ),
    .host_rsp_o       ( host_rsp_o       ),
    .host_rsp_valid_o ( host_rsp_valid_o ),
    .host_rsp_ready_i ( host_rsp_ready_i ),
    .mem_req_o        ( mem_req          ),
    .mem_en_o         ( mem_en           ),
    .mem_rdata_i      ( mem_rdata        ),
    .cfg_req_o        ( cfg_req          ),
    .cfg_en_o         ( cfg_en           ),
    .cfg_rdata_i      ( cfg_rdata        )
  );

  l2_memory #(
    .NB_L2_BANKS   ( NB_L2_BANKS   ),
    .L2_BANK_WORDS ( L2_BANK_WORDS )
  ) i_l2_memory (
    .clk_i     ( clk_i     ),
    .mem_req_i ( mem_req   ),
    .mem_en_i  ( mem_en    ),
    .rdata_o   ( mem_rdata )
  );

  cfg_regs i_cfg_regs (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .cfg_req_i     ( cfg_req       ),
    .cfg_en_i      ( cfg_en        ),
    .rdata_o       ( cfg_rdata     ),
    .dma_evt_i     ( dma_evt       ),
    .cluster_eoc_i ( cluster_eoc_i ),
    .irq_o         ( irq_o         )
  );

  // Cluster DMA event enters through the four-phase receiver
  evt_receiver i_evt_receiver (
    .clk_i    ( clk_i              ),
    .arst_n_i ( arst_n_i           ),
    .valid_i  ( dma_pe_evt_valid_i ),
    .ack_o    ( dma_pe_evt_ack_o   ),
    .evt_o    ( dma_evt            )
  );

endmodule

//--- logic/host_router.sv
// ==========================================================
// Host router
// Accepts one host request at a time, decodes the region and
// drives the L2 or config target, then holds the response
// ==========================================================

`timescale 1ns/1ps

module host_router #(
  parameter int unsigned NB_L2_BANKS   = 4,
  parameter int unsigned L2_BANK_WORDS = 256
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  host_pkg::host_req_t  host_req_i,
  input  logic                 host_req_valid_i,
  output logic                 host_req_ready_o,
  output host_pkg::host_rsp_t  host_rsp_o,
  output logic                 host_rsp_valid_o,
  input  logic                 host_rsp_ready_i,
  output host_pkg::mem_req_t   mem_req_o,
  output logic                 mem_en_o,
  input  logic [31:0]          mem_rdata_i,
  output host_pkg::cfg_req_t   cfg_req_o,
  output logic                 cfg_en_o,
  input  logic [31:0]          cfg_rdata_i
);

  localparam int unsigned L2_WORDS = NB_L2_BANKS * L2_BANK_WORDS;

  typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_RESP} state_e;
  typedef enum logic [1:0] {TGT_L2, TGT_CFG, TGT_ERR} tgt_e;

  state_e              state_q;
  tgt_e                tgt_q;
  tgt_e                tgt_d;
  logic                we_q;
  logic                phase_q;
  logic                mem_en_q;
  logic                cfg_en_q;
  logic                accept;
  logic                capture;
  logic                l2_in_range;
  host_pkg::mem_req_t  mem_req_q;
  host_pkg::cfg_req_t  cfg_req_q;
  host_pkg::host_rsp_t rsp_q;

  assign accept      = host_req_valid_i && (state_q == ST_IDLE);
  assign capture     = (state_q == ST_WAIT) && phase_q;
  assign l2_in_range = 32'(host_req_i.addr.offset.l2.word) < L2_WORDS;

  always_comb begin
    case (host_req_i.addr.region)
      host_pkg::REGION_L2:  tgt_d = l2_in_range ? TGT_L2 : TGT_ERR;
      host_pkg::REGION_CFG: tgt_d = TGT_CFG;
      default:              tgt_d = TGT_ERR;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= ST_IDLE;
      tgt_q    <= TGT_ERR;
      we_q     <= 1'b0;
      phase_q  <= 1'b0;
      mem_en_q <= 1'b0;
      cfg_en_q <= 1'b0;
    end else begin
      mem_en_q <= 1'b0;
      cfg_en_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            state_q  <= ST_WAIT;
            tgt_q    <= tgt_d;
            we_q     <= host_req_i.we;
            mem_en_q <= (tgt_d == TGT_L2);
            cfg_en_q <= (tgt_d == TGT_CFG);
          end
        end
        // Enable cycle first, then the cycle the target returns data
        ST_WAIT: begin
          phase_q <= ~phase_q;
          if (phase_q) state_q <= ST_RESP;
        end
        ST_RESP: begin
          if (host_rsp_ready_i) state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      mem_req_q.word  <= host_req_i.addr.offset.l2.word;
      mem_req_q.we    <= host_req_i.we;
      mem_req_q.wdata <= host_req_i.wdata;
      mem_req_q.be    <= host_req_i.be;
      cfg_req_q.idx   <= host_req_i.addr.offset.cfg.reg_idx;
      cfg_req_q.we    <= host_req_i.we;
      cfg_req_q.wdata <= host_req_i.wdata;
      cfg_req_q.be    <= host_req_i.be;
    end
    if (capture) begin
      rsp_q.err <= (tgt_q == TGT_ERR);
      if ((tgt_q == TGT_ERR) || we_q) rsp_q.rdata <= '0;
      else if (tgt_q == TGT_L2)       rsp_q.rdata <= mem_rdata_i;
      else                            rsp_q.rdata <= cfg_rdata_i;
    end
  end

  assign host_req_ready_o = (state_q == ST_IDLE);
  assign host_rsp_valid_o = (state_q == ST_RESP);
  assign host_rsp_o       = rsp_q;
  assign mem_req_o        = mem_req_q;
  assign mem_en_o         = mem_en_q;
  assign cfg_req_o        = cfg_req_q;
  assign cfg_en_o         = cfg_en_q;

endmodule

//--- tb/host_domain_assertions.sv
// ==========================================================
// Host domain port assertions
// Handshake stability, response latency and event crossing
// ==========================================================

`timescale 1ns/1ps

module host_domain_assertions (
  input logic                clk_i,
  input logic                arst_n_i,
  input host_pkg::host_req_t host_req_i,
  input logic                host_req_valid_i,
  input logic                host_req_ready_o,
  input host_pkg::host_rsp_t host_rsp_o,
  input logic                host_rsp_valid_o,
  input logic                host_rsp_ready_i,
  input logic                dma_pe_evt_valid_i,
  input logic                dma_pe_evt_ack_o,
  input logic                irq_o
);

  int unsigned fail_cnt = 0;
  logic        accepted;

  assign accepted = host_req_valid_i && host_req_ready_o;

  req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $past(host_req_valid_i && !host_req_ready_o) |->
      host_req_valid_i && (host_req_i == $past(host_req_i)))
    else begin
      $error("request changed or dropped while waiting for ready");
      fail_cnt++;
    end

  rsp_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $past(host_rsp_valid_o && !host_rsp_ready_i) |->
      host_rsp_valid_o && (host_rsp_o == $past(host_rsp_o)))
    else begin
      $error("response changed or dropped before it was consumed");
      fail_cnt++;
    end

  // Valid is first sampled high three ticks after the accepting edge
  rsp_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(host_rsp_valid_o) == $past(accepted, 3))
    else begin
      $error("response did not rise two edges after acceptance");
      fail_cnt++;
    end

  ready_blocked: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (host_rsp_valid_o || $past(accepted) || $past(accepted, 2)) |-> !host_req_ready_o)
    else begin
      $error("request channel ready while a response is outstanding");
      fail_cnt++;
    end

  ack_follows: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    dma_pe_evt_ack_o == $past(dma_pe_evt_valid_i, 2))
    else begin
      $error("event ack does not follow valid by two edges");
      fail_cnt++;
    end

  reset_values: assert property (@(posedge clk_i)
    $rose(arst_n_i) |->
      host_req_ready_o && !host_rsp_valid_o && !dma_pe_evt_ack_o && !irq_o)
    else begin
      $error("control outputs not at their reset values");
      fail_cnt++;
    end

endmodule

bind host_domain host_domain_assertions i_host_domain_assertions (
  .clk_i,
  .arst_n_i,
  .host_req_i,
  .host_req_valid_i,
  .host_req_ready_o,
  .host_rsp_o,
  .host_rsp_valid_o,
  .host_rsp_ready_i,
  .dma_pe_evt_valid_i,
  .dma_pe_evt_ack_o,
  .irq_o
);

//--- tb/tb_host_domain.sv
// ==========================================================
// Host domain testbench
// Random L2 traffic, register map, back-pressure, DMA event
// crossing and interrupt tests with a reference model
// ==========================================================

`timescale 1ns/1ps

module tb_host_domain;

  localparam int NB_BANKS   = 4;
  localparam int BANK_WORDS = 256;
  localparam int L2_WORDS   = NB_BANKS * BANK_WORDS;
  localparam int CLK_PERIOD = 100;
  localparam int N_TESTS    = 6;

  logic                clk_i;
  logic                arst_n_i;
  host_pkg::host_req_t host_req_i;
  logic                host_req_valid_i;
  logic                host_req_ready_o;
  host_pkg::host_rsp_t host_rsp_o;
  logic                host_rsp_valid_o;
  logic                host_rsp_ready_i;
  logic                dma_pe_evt_valid_i;
  logic                dma_pe_evt_ack_o;
  logic                cluster_eoc_i;
  logic                irq_o;

  logic [31:0] lcg_state = 32'he7ce_feea;
  logic [31:0] l2_model [L2_WORDS];
  int          bad_regions [3] = '{0, 3, 15};
  int          errors = 0;
  int          err_mark = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;

  host_domain #(
    .NB_L2_BANKS   ( NB_BANKS   ),
    .L2_BANK_WORDS ( BANK_WORDS )
  ) DUT (
    .clk_i              ( clk_i              ),
    .arst_n_i           ( arst_n_i           ),
    .host_req_i         ( host_req_i         ),
    .host_req_valid_i   ( host_req_valid_i   ),
    .host_req_ready_o   ( host_req_ready_o   ),
    .host_rsp_o         ( host_rsp_o         ),
    .host_rsp_valid_o   ( host_rsp_valid_o   ),
    .host_rsp_ready_i   ( host_rsp_ready_i   ),
    .dma_pe_evt_valid_i ( dma_pe_evt_valid_i ),
    .dma_pe_evt_ack_o   ( dma_pe_evt_ack_o   ),
    .cluster_eoc_i      ( cluster_eoc_i      ),
    .irq_o              ( irq_o              )
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] merge(logic [31:0] old, logic [31:0] wd, logic [3:0] be);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) res[8*i +: 8] = wd[8*i +: 8];
    end
    return res;
  endfunction

  function automatic logic [27:0] l2_off(int w);
    return {26'(w), 2'b00};
  endfunction

  function automatic logic [27:0] cfg_off(logic [3:0] idx);
    return {22'd0, idx, 2'b00};
  endfunction

  function automatic host_pkg::host_req_t make_req(logic [3:0] region, logic [27:0] offset,
                                                   logic we, logic [31:0] wdata, logic [3:0] be);
    host_pkg::host_req_t req;
    req.addr.region = host_pkg::region_e'(region);
    req.addr.offset = offset;
    req.we          = we;
    req.wdata       = wdata;
    req.be          = be;
    return req;
  endfunction

  function automatic int failures();
    return errors + DUT.i_host_domain_assertions.fail_cnt;
  endfunction

  function automatic void check(string name, logic [31:0] exp, logic [31:0] act);
    if (act !== exp) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endfunction

  function automatic void check_rsp(string name, logic [31:0] exp_data, logic exp_err,
                                    host_pkg::host_rsp_t rsp);
    check({name, " rdata"}, exp_data, rsp.rdata);
    check({name, " err"}, {31'd0, exp_err}, {31'd0, rsp.err});
  endfunction

  // All driving happens 10 ns after the rising edge
  task automatic wait_cycle();
    @(posedge clk_i);
    #10;
  endtask

  task automatic send_req(host_pkg::host_req_t req);
    host_req_i       = req;
    host_req_valid_i = 1'b1;
    while (!host_req_ready_o) wait_cycle();
    wait_cycle();
    host_req_valid_i = 1'b0;
  endtask

  task automatic get_rsp(input int stall, output host_pkg::host_rsp_t rsp);
    while (!host_rsp_valid_o) wait_cycle();
    repeat (stall) wait_cycle();
    rsp              = host_rsp_o;
    host_rsp_ready_i = 1'b1;
    wait_cycle();
    host_rsp_ready_i = 1'b0;
  endtask

  task automatic access(input logic [3:0] region, input logic [27:0] offset, input logic we,
                        input logic [31:0] wdata, input logic [3:0] be,
                        output host_pkg::host_rsp_t rsp);
    send_req(make_req(region, offset, we, wdata, be));
    get_rsp(0, rsp);
  endtask

  task automatic send_event();
    dma_pe_evt_valid_i = 1'b1;
    while (!dma_pe_evt_ack_o) wait_cycle();
    dma_pe_evt_valid_i = 1'b0;
    while (dma_pe_evt_ack_o) wait_cycle();
  endtask

  task automatic end_test(string name);
    if (failures() == err_mark) begin
      tests_passed++;
      $display("Test %s passed", name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", name, failures() - err_mark);
    end
    err_mark = failures();
  endtask

  initial begin : watchdog
    #(N_TESTS * 2000 * CLK_PERIOD);
    $display("Watchdog expired, the tests did not complete in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin : main
    host_pkg::host_rsp_t rsp;
    host_pkg::host_req_t next;
    logic [31:0]         d;
    logic [31:0]         r;
    logic [31:0]         scratch;
    int                  base;
    int                  w;
    int                  stall;
    int                  n_evt;

    host_req_i         = '0;
    host_req_valid_i   = 1'b0;
    host_rsp_ready_i   = 1'b0;
    dma_pe_evt_valid_i = 1'b0;
    cluster_eoc_i      = 1'b0;
    arst_n_i           = 1'b0;
    repeat (10) @(posedge clk_i);
    #10;
    arst_n_i = 1'b1;
    wait_cycle();

    // Consecutive words walk through every bank
    base = int'(next_random() % L2_WORDS);
    for (int i = 0; i < 16; i++) begin
      w = (base + i) % L2_WORDS;
      d = next_random();
      access(host_pkg::REGION_L2, l2_off(w), 1'b1, d, 4'hf, rsp);
      check_rsp("l2_write", 32'd0, 1'b0, rsp);
      l2_model[w] = d;
    end
    for (int i = 0; i < 16; i++) begin
      w = (base + i) % L2_WORDS;
      d = next_random();
      r = next_random();
      access(host_pkg::REGION_L2, l2_off(w), 1'b1, d, r[3:0], rsp);
      l2_model[w] = merge(l2_model[w], d, r[3:0]);
    end
    for (int i = 0; i < 16; i++) begin
      w = (base + i) % L2_WORDS;
      access(host_pkg::REGION_L2, l2_off(w), 1'b0, '0, '0, rsp);
      check_rsp("l2_read", l2_model[w], 1'b0, rsp);
    end
    end_test("l2_random_access");

    for (int k = 1; k < 4; k++) begin
      access(host_pkg::REGION_L2, l2_off(base + k * L2_WORDS), 1'b1, next_random(), 4'hf, rsp);
      check_rsp("oor_write", 32'd0, 1'b1, rsp);
      access(host_pkg::REGION_L2, l2_off(base + k * L2_WORDS), 1'b0, '0, '0, rsp);
      check_rsp("oor_read", 32'd0, 1'b1, rsp);
    end
    foreach (bad_regions[j]) begin
      access(4'(bad_regions[j]), l2_off(base), 1'b1, next_random(), 4'hf, rsp);
      check_rsp("bad_region_write", 32'd0, 1'b1, rsp);
      access(4'(bad_regions[j]), l2_off(base), 1'b0, '0, '0, rsp);
      check_rsp("bad_region_read", 32'd0, 1'b1, rsp);
    end
    access(host_pkg::REGION_L2, l2_off(base), 1'b0, '0, '0, rsp);
    check_rsp("alias_read", l2_model[base], 1'b0, rsp);
    end_test("address_errors");

    access(host_pkg::REGION_CFG, cfg_off(host_pkg::CFG_ID), 1'b0, '0, '0, rsp);
    check_rsp("id_read", host_pkg::HOST_ID, 1'b0, rsp);
    scratch = next_random();
    access(host_pkg::REGION_CFG, cfg_off(host_pkg::CFG_SCRATCH), 1'b1, scratch, 4'hf, rsp);
    d = next_random();
    access(host_pkg::REGION_CFG, cfg_off(host_pkg::CFG_SCRATCH), 1'b1, d, 4'b0101, rsp);
    scratch = merge(scratch, d, 4'b0101);
    access(host_pkg::REGION_CFG, cfg_off(host_pkg::CFG_SCRATCH), 1'b0, '0, '0, rsp);
    check_rsp("scratch_read", scratch, 1'b0, rsp);
    for (int idx = 5; idx < 16; idx++) begin
      access(host_pkg::REGION_CFG, cfg_off(4'(idx)), 1'b1, next_random(), 4'hf, rsp);
      check_rsp("unmapped_write", 32'd0, 1'b0, rsp);
      access(host_pkg::REGION_CFG, cfg_off(4'(idx)), 1'b0, '0, '0, rsp);
      check_rsp("unmapped_read", host_pkg::CFG_DEFAULT_RDATA, 1'b0, rsp);
    end
    end_test("config_registers");

    // Next request waits on the channel while the response is held
    for (int i = 0; i < 6; i++) begin
      w     = int'(next_random() % L2_WORDS);
      d     = next_random();
      stall = int'(next_random() % 8) + 1;
      send_req(make_req(host_pkg::REGION_L2, l2_off(w), 1'b1, d, 4'hf));
      l2_model[w] = d;
      next = make_req(host_pkg::REGION_L2, l2_off(w), 1'b0, '0, '0);
      fork
        get_rsp(stall, rsp);
        send_req(next);
      join
      check_rsp("bp_write", 32'd0, 1'b0, rsp);
      stall = int'(next_random() % 8) + 1;
      get_rsp(stall, rsp);
      check_rsp("bp_read", l2_model[w], 1'b0, rsp);
    end
    end_test("back_pressure");

    n_evt = int'(next_random() % 4) + 2;
    for (int i = 0; i < n_evt; i++) send_event();
    access(host_pkg::REGION_CFG, cfg_off(host_pkg::CFG_EVT_COUNT), 1'b0, '0, '0, rsp);
    check_rsp("evt_count", 32'(n_evt), 1'b0, rsp);
    check("irq_masked", 32'd0, {31'd0, irq_o});
    access(host_pkg::REGION_CFG, cfg_off(host_pkg::CFG_IRQ_STATUS), 1'b0, '0, '0, rsp);
    check_rsp("evt_status", 32'd1, 1'b0, rsp);
    access(host_pkg::REGION_CFG, cfg_off(host_pkg::CFG_IRQ_MASK), 1'b1, 32'd1, 4'hf, rsp);
    check("irq_enabled", 32'd1, {31'd0, irq_o});
    access(host_pkg::REGION_CFG, cfg_off(host_pkg::CFG_IRQ_STATUS), 1'b1, 32'd1, 4'hf, rsp);
    check("irq_cleared", 32'd0, {31'd0, irq_o});
    access(host_pkg::REGION_CFG, cfg_off(host_pkg::CFG_IRQ_STATUS), 1'b0, '0, '0, rsp);
    check_rsp("evt_status_clear", 32'd0, 1'b0, rsp);
    end_test("dma_events");

    cluster_eoc_i = 1'b1;
    access(host_pkg::REGION_CFG, cfg_off(host_pkg::CFG_IRQ_MASK), 1'b1, 32'd2, 4'hf, rsp);
    check("eoc_irq", 32'd1, {31'd0, irq_o});
    // Clear loses against a level that is still high
    access(host_pkg::REGION_CFG, cfg_off(host_pkg::CFG_IRQ_STATUS), 1'b1, 32'd2, 4'hf, rsp);
    access(host_pkg::REGION_CFG, cfg_off(host_pkg::CFG_IRQ_STATUS), 1'b0, '0, '0, rsp);
    check_rsp("eoc_status_held", 32'd2, 1'b0, rsp);
    cluster_eoc_i = 1'b0;
    access(host_pkg::REGION_CFG, cfg_off(host_pkg::CFG_IRQ_STATUS), 1'b1, 32'd2, 4'hf, rsp);
    access(host_pkg::REGION_CFG, cfg_off(host_pkg::CFG_IRQ_STATUS), 1'b0, '0, '0, rsp);
    check_rsp("eoc_status_clear", 32'd0, 1'b0, rsp);
    check("eoc_irq_cleared", 32'd0, {31'd0, irq_o});
    end_test("cluster_eoc");

    $display("Tests passed %0d, failed %0d, check errors %0d, assertion failures %0d",
             tests_passed, tests_failed, errors, DUT.i_host_domain_assertions.fail_cnt);
    if (failures() == 0 && tests_failed == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
